//--- Makefile
# Verilator flow for the coefficient sampler

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only -Wall --timing --assert
TOP       ?= sampler_tb
RTL_TOP   ?= sampler_top
FILELIST  ?= sampler.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qx "NO ERRORS" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- hdl/coeff_collector.sv
// job control for the coefficient sampler
// mode latch, sampler enables and word hold select
// beat count to one polynomial, destination address generation
// steering of beats to the NTT stream or the memory write port
`timescale 1ns/1ps

module coeff_collector (
  input  logic                                    clk,
  input  logic                                    rst_b,
  input  logic                                    start_i,
  input  dilithium_params_pkg::sampler_mode_e     mode_i,
  input  logic [dilithium_params_pkg::ADDR_W-1:0] dest_base_addr_i,
  input  logic                                    uni_hold_i,
  input  logic                                    bnd_hold_i,
  input  sampler_bus_pkg::coeff_beat_t            uni_beat_i,
  input  sampler_bus_pkg::coeff_beat_t            bnd_beat_i,
  output logic                                    uni_enable_o,
  output logic                                    bnd_enable_o,
  output logic                                    word_hold_o,
  output logic                                    busy_o,
  output logic                                    done_o,
  output sampler_bus_pkg::ntt_out_t               ntt_out_o,
  output sampler_bus_pkg::mem_wr_t                mem_wr_o
);
  import dilithium_params_pkg::*;

  localparam int CNT_W = $clog2(BEATS_PER_POLY);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_RUN,
    ST_DONE
  } coll_state_e;

  coll_state_e       state_q;
  coll_state_e       state_d;
  sampler_mode_e     mode_q;
  logic [CNT_W-1:0]  beat_cnt_q;
  logic [ADDR_W-1:0] addr_q;
  logic              running;
  logic              start_ok;
  logic              beat_vld;
  logic              last_beat;

  assign running   = (state_q == ST_RUN);
  assign start_ok  = start_i & ~running;

  // exactly one sampler runs, the other stays cleared
  assign uni_enable_o = running & (mode_q == MODE_REJ_UNIFORM);
  assign bnd_enable_o = running & (mode_q == MODE_REJ_BOUNDED);

  assign beat_vld  = (uni_enable_o & uni_beat_i.dv) | (bnd_enable_o & bnd_beat_i.dv);
  assign last_beat = beat_vld & (beat_cnt_q == CNT_W'(BEATS_PER_POLY - 1));

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      ST_IDLE: begin
        if (start_i) begin
          state_d = ST_RUN;
        end
      end
      ST_RUN: begin
        if (last_beat) begin
          state_d = ST_DONE;
        end
      end
      // single done cycle, a new start may follow at once
      ST_DONE: begin
        state_d = start_i ? ST_RUN : ST_IDLE;
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      state_q    <= ST_IDLE;
      mode_q     <= MODE_REJ_UNIFORM;
      beat_cnt_q <= '0;
      addr_q     <= '0;
    end else begin
      state_q <= state_d;
      if (start_ok) begin
        mode_q     <= mode_i;
        beat_cnt_q <= '0;
        addr_q     <= dest_base_addr_i;
      end else if (beat_vld) begin
        beat_cnt_q <= beat_cnt_q + 1'b1;
        if (bnd_enable_o) begin
          addr_q <= addr_q + 1'b1;
        end
      end
    end
  end

  assign busy_o      = running;
  assign done_o      = (state_q == ST_DONE);
  assign word_hold_o = (uni_enable_o & uni_hold_i) | (bnd_enable_o & bnd_hold_i);

  always_comb begin
    ntt_out_o.dv   = uni_enable_o & uni_beat_i.dv;
    ntt_out_o.data = uni_beat_i.data;
    mem_wr_o.dv    = bnd_enable_o & bnd_beat_i.dv;
    mem_wr_o.addr  = addr_q;
    mem_wr_o.data  = bnd_beat_i.data;
  end

  // the idle sampler stays quiet on both its beat and its hold
  a_beat_mutex: assert property (@(posedge clk) disable iff (!rst_b)
    !(uni_beat_i.dv && bnd_beat_i.dv));

  a_hold_mutex: assert property (@(posedge clk) disable iff (!rst_b)
    !(uni_hold_i && bnd_hold_i));

endmodule

//--- hdl/dilithium_params_pkg.sv
// Dilithium field modulus and coefficient width
// polynomial, input word and memory address sizing
// candidate widths and the bounded sampling constants
// sampler mode enum
package dilithium_params_pkg;

  // field
  localparam logic [31:0] DILITHIUM_Q = 32'd8380417;
  localparam int          Q_W         = 23;

  // polynomial shape, four coefficients per beat
  localparam int COEFF_CNT      = 256;
  localparam int COEFF_PER_CLK  = 4;
  localparam int BEATS_PER_POLY = COEFF_CNT / COEFF_PER_CLK;

  // squeeze word and destination memory
  localparam int WORD_W = 96;
  localparam int ADDR_W = 14;

  // candidate widths
  localparam int REJS_SAMPLE_W = 24;
  localparam int REJB_SAMPLE_W = 4;

  // bounded sampling, keep b < 15 and map to eta - (b mod 5)
  localparam int REJB_LIMIT = 15;
  localparam int ETA        = 2;

  typedef enum logic {
    MODE_REJ_UNIFORM = 1'b0,
    MODE_REJ_BOUNDED = 1'b1
  } sampler_mode_e;

endpackage

//--- hdl/rej_bounded_sampler.sv
// bounded rejection sampler
// keeps 4-bit candidates below 15 and maps b to 2 - (b mod 5) mod q
// compaction buffer of up to eleven, four coefficients per beat
`timescale 1ns/1ps

module rej_bounded_sampler (
  input  logic                                    clk,
  input  logic                                    rst_b,
  input  logic                                    enable_i,
  input  logic                                    word_valid_i,
  input  logic [dilithium_params_pkg::WORD_W-1:0] word_i,
  output logic                                    word_hold_o,
  output sampler_bus_pkg::coeff_beat_t            beat_o
);
  import dilithium_params_pkg::*;
  import sampler_bus_pkg::*;

  localparam int NUM_CAND  = 2 * COEFF_PER_CLK;
  localparam int BUF_DEPTH = NUM_CAND + COEFF_PER_CLK - 1;

  logic                        clear;
  logic                        piso_hold;
  logic                        grp_valid;
  logic                        full_beat;
  logic                        take;
  logic                        emit;
  rejb_sample_t [NUM_CAND-1:0] cand;
  coeff_t [NUM_CAND-1:0]       mapped;
  logic [NUM_CAND-1:0]         keep;
  coeff_t [BUF_DEPTH-1:0]      buf_q;
  coeff_t [BUF_DEPTH-1:0]      buf_d;
  logic [3:0]                  cnt_q;
  logic [3:0]                  cnt_d;

  // eta - (b mod 5), negatives wrap to q-1 and q-2
  function automatic coeff_t map_eta(input rejb_sample_t b);
    logic [3:0] m;
    m = b;
    if (m >= 4'd10) begin
      m = m - 4'd10;
    end else if (m >= 4'd5) begin
      m = m - 4'd5;
    end
    if (m <= 4'(ETA)) begin
      map_eta = coeff_t'(4'(ETA) - m);
    end else begin
      map_eta = coeff_t'(DILITHIUM_Q) - coeff_t'(m - 4'(ETA));
    end
  endfunction

  assign clear = ~enable_i;

  sample_piso #(
    .sample_t (rejb_sample_t),
    .NUM_OUT  (NUM_CAND)
  ) i_piso (
    .clk       (clk),
    .rst_b     (rst_b),
    .clear_i   (clear),
    .valid_i   (word_valid_i),
    .word_i    (word_i),
    .hold_o    (piso_hold),
    .valid_o   (grp_valid),
    .hold_i    (full_beat),
    .samples_o (cand)
  );

  assign full_beat = (cnt_q >= 4'(COEFF_PER_CLK));
  assign take      = grp_valid & ~full_beat;
  assign emit      = enable_i & full_beat;

  always_comb begin
    for (int i = 0; i < NUM_CAND; i++) begin
      keep[i]   = (cand[i] < rejb_sample_t'(REJB_LIMIT));
      mapped[i] = map_eta(cand[i]);
    end
  end

  // up to eight new values behind at most three left over
  always_comb begin
    logic [3:0] pos;
    buf_d = buf_q;
    cnt_d = cnt_q;
    pos   = cnt_q;
    if (emit) begin
      for (int j = 0; j < BUF_DEPTH - COEFF_PER_CLK; j++) begin
        buf_d[j] = buf_q[j+COEFF_PER_CLK];
      end
      cnt_d = cnt_q - 4'(COEFF_PER_CLK);
    end else if (take) begin
      for (int i = 0; i < NUM_CAND; i++) begin
        if (keep[i]) begin
          buf_d[pos] = mapped[i];
          pos        = pos + 1'b1;
        end
      end
      cnt_d = pos;
    end
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      cnt_q <= '0;
    end else if (clear) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  always_ff @(posedge clk) begin
    buf_q <= buf_d;
  end

  assign word_hold_o = enable_i & piso_hold;
  assign beat_o.dv   = emit;
  assign beat_o.data = buf_q[COEFF_PER_CLK-1:0];

  a_buf_cnt: assert property (@(posedge clk) disable iff (!rst_b)
    cnt_q <= 4'(BUF_DEPTH));

endmodule

//--- hdl/rej_uniform_sampler.sv
// uniform rejection sampler
// masks 24-bit candidates to 23 bits and keeps those below q
// compaction buffer of up to seven, four coefficients per beat
`timescale 1ns/1ps

module rej_uniform_sampler (
  input  logic                                    clk,
  input  logic                                    rst_b,
  input  logic                                    enable_i,
  input  logic                                    word_valid_i,
  input  logic [dilithium_params_pkg::WORD_W-1:0] word_i,
  output logic                                    word_hold_o,
  output sampler_bus_pkg::coeff_beat_t            beat_o
);
  import dilithium_params_pkg::*;
  import sampler_bus_pkg::*;

  localparam int BUF_DEPTH = 2 * COEFF_PER_CLK - 1;

  logic                             clear;
  logic                             piso_hold;
  logic                             grp_valid;
  logic                             full_beat;
  logic                             take;
  logic                             emit;
  rejs_sample_t [COEFF_PER_CLK-1:0] cand;
  coeff_t [COEFF_PER_CLK-1:0]       masked;
  logic [COEFF_PER_CLK-1:0]         keep;
  coeff_t [BUF_DEPTH-1:0]           buf_q;
  coeff_t [BUF_DEPTH-1:0]           buf_d;
  logic [3:0]                       cnt_q;
  logic [3:0]                       cnt_d;

  assign clear = ~enable_i;

  sample_piso #(
    .sample_t (rejs_sample_t),
    .NUM_OUT  (COEFF_PER_CLK)
  ) i_piso (
    .clk       (clk),
    .rst_b     (rst_b),
    .clear_i   (clear),
    .valid_i   (word_valid_i),
    .word_i    (word_i),
    .hold_o    (piso_hold),
    .valid_o   (grp_valid),
    .hold_i    (full_beat),
    .samples_o (cand)
  );

  // take a group only while a whole group still fits
  assign full_beat = (cnt_q >= 4'(COEFF_PER_CLK));
  assign take      = grp_valid & ~full_beat;
  assign emit      = enable_i & full_beat;

  always_comb begin
    for (int i = 0; i < COEFF_PER_CLK; i++) begin
      masked[i] = cand[i][Q_W-1:0];
      keep[i]   = (masked[i] < coeff_t'(DILITHIUM_Q));
    end
  end

  // kept values fill the next free slots, beat pops the oldest four
  always_comb begin
    logic [3:0] pos;
    buf_d = buf_q;
    cnt_d = cnt_q;
    pos   = cnt_q;
    if (emit) begin
      for (int j = 0; j < BUF_DEPTH - COEFF_PER_CLK; j++) begin
        buf_d[j] = buf_q[j+COEFF_PER_CLK];
      end
      cnt_d = cnt_q - 4'(COEFF_PER_CLK);
    end else if (take) begin
      for (int i = 0; i < COEFF_PER_CLK; i++) begin
        if (keep[i]) begin
          buf_d[pos] = masked[i];
          pos        = pos + 1'b1;
        end
      end
      cnt_d = pos;
    end
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      cnt_q <= '0;
    end else if (clear) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  always_ff @(posedge clk) begin
    buf_q <= buf_d;
  end

  assign word_hold_o = enable_i & piso_hold;
  assign beat_o.dv   = emit;
  assign beat_o.data = buf_q[COEFF_PER_CLK-1:0];

  a_buf_cnt: assert property (@(posedge clk) disable iff (!rst_b)
    cnt_q <= 4'(BUF_DEPTH));

endmodule

//--- hdl/sample_piso.sv
// sample unpacker, one squeeze word in, groups of candidates out
// holds the word until every group has been taken
// sample type and group size set by parameters
`timescale 1ns/1ps

module sample_piso #(
  parameter type sample_t = logic [3:0],
  parameter int  NUM_OUT  = 8
) (
  input  logic                                    clk,
  input  logic                                    rst_b,
  input  logic                                    clear_i,
  input  logic                                    valid_i,
  input  logic [dilithium_params_pkg::WORD_W-1:0] word_i,
  output logic                                    hold_o,
  output logic                                    valid_o,
  input  logic                                    hold_i,
  output sample_t [NUM_OUT-1:0]                   samples_o
);
  import dilithium_params_pkg::*;

  localparam int GRP_W   = NUM_OUT * $bits(sample_t);
  localparam int NUM_GRP = WORD_W / GRP_W;
  localparam int IDX_W   = (NUM_GRP > 1) ? $clog2(NUM_GRP) : 1;

  logic [WORD_W-1:0] word_q;
  logic              full;
  logic [IDX_W-1:0]  grp_idx;
  logic              load;
  logic              take;
  logic              last_grp;

  // new word only into an empty buffer
  assign load     = valid_i & ~full & ~clear_i;
  assign take     = full & ~hold_i;
  assign last_grp = (grp_idx == IDX_W'(NUM_GRP - 1));

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      full    <= 1'b0;
      grp_idx <= '0;
    end else if (clear_i) begin
      full    <= 1'b0;
      grp_idx <= '0;
    end else if (load) begin
      full    <= 1'b1;
      grp_idx <= '0;
    end else if (take) begin
      if (last_grp) begin
        full    <= 1'b0;
        grp_idx <= '0;
      end else begin
        grp_idx <= grp_idx + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      word_q <= word_i;
    end
  end

  assign hold_o  = full;
  assign valid_o = full;

  // group 0 in the low bits, sample 0 lowest within a group
  assign samples_o = word_q[grp_idx*GRP_W +: GRP_W];

  // a refused word stays on the input until it is taken
  a_word_stable: assert property (@(posedge clk) disable iff (!rst_b)
    valid_i && hold_o && !clear_i |=> valid_i && $stable(word_i));

endmodule

//--- hdl/sampler_bus_pkg.sv
// coefficient type and the four-coefficient beat
// NTT stream and memory write structs
// candidate payload types for the sample unpacker
package sampler_bus_pkg;
  import dilithium_params_pkg::*;

  typedef logic [Q_W-1:0] coeff_t;

  // one beat from a sampler toward the collector
  typedef struct packed {
    logic                       dv;
    coeff_t [COEFF_PER_CLK-1:0] data;
  } coeff_beat_t;

  // same layout on the way to the NTT
  typedef coeff_beat_t ntt_out_t;

  // write toward the polynomial memory
  typedef struct packed {
    logic                       dv;
    logic [ADDR_W-1:0]          addr;
    coeff_t [COEFF_PER_CLK-1:0] data;
  } mem_wr_t;

  // raw candidates as cut from the squeeze word
  typedef logic [REJS_SAMPLE_W-1:0] rejs_sample_t;
  typedef logic [REJB_SAMPLE_W-1:0] rejb_sample_t;

endpackage

//--- hdl/sampler_top.sv
// coefficient sampler top level
// uniform and bounded samplers side by side on one word stream
// collector for job control and output steering
`timescale 1ns/1ps

module sampler_top (
  input  logic                                    clk,
  input  logic                                    rst_b,
  input  logic                                    start_i,
  input  dilithium_params_pkg::sampler_mode_e     mode_i,
  input  logic [dilithium_params_pkg::ADDR_W-1:0] dest_base_addr_i,
  input  logic                                    word_valid_i,
  input  logic [dilithium_params_pkg::WORD_W-1:0] word_i,
  output logic                                    word_hold_o,
  output logic                                    busy_o,
  output logic                                    done_o,
  output sampler_bus_pkg::ntt_out_t               ntt_out_o,
  output sampler_bus_pkg::mem_wr_t                mem_wr_o
);
  import sampler_bus_pkg::*;

  logic        uni_enable;
  logic        bnd_enable;
  logic        uni_hold;
  logic        bnd_hold;
  coeff_beat_t uni_beat;
  coeff_beat_t bnd_beat;

  // both samplers see the word bus, only the enabled one takes it
  rej_uniform_sampler i_uni (
    .clk          (clk),
    .rst_b        (rst_b),
    .enable_i     (uni_enable),
    .word_valid_i (word_valid_i),
    .word_i       (word_i),
    .word_hold_o  (uni_hold),
    .beat_o       (uni_beat)
  );

  rej_bounded_sampler i_bnd (
    .clk          (clk),
    .rst_b        (rst_b),
    .enable_i     (bnd_enable),
    .word_valid_i (word_valid_i),
    .word_i       (word_i),
    .word_hold_o  (bnd_hold),
    .beat_o       (bnd_beat)
  );

  coeff_collector i_coll (
    .clk              (clk),
    .rst_b            (rst_b),
    .start_i          (start_i),
    .mode_i           (mode_i),
    .dest_base_addr_i (dest_base_addr_i),
    .uni_hold_i       (uni_hold),
    .bnd_hold_i       (bnd_hold),
    .uni_beat_i       (uni_beat),
    .bnd_beat_i       (bnd_beat),
    .uni_enable_o     (uni_enable),
    .bnd_enable_o     (bnd_enable),
    .word_hold_o      (word_hold_o),
    .busy_o           (busy_o),
    .done_o           (done_o),
    .ntt_out_o        (ntt_out_o),
    .mem_wr_o         (mem_wr_o)
  );

endmodule

//--- sampler.f
hdl/dilithium_params_pkg.sv
hdl/sampler_bus_pkg.sv
hdl/sample_piso.sv
hdl/rej_uniform_sampler.sv
hdl/rej_bounded_sampler.sv
hdl/coeff_collector.sv
hdl/sampler_top.sv
testbench/sampler_tb.sv

//--- testbench/sampler_tb.sv
// testbench for the coefficient sampler
// job table applied in a loop, back-to-back jobs in alternating modes
// random word source with valid gaps, reference model and checks
`timescale 1ns/1ps

module sampler_tb;
  import dilithium_params_pkg::*;
  import sampler_bus_pkg::*;

  localparam int NUM_JOBS    = 6;
  localparam int JOB_TIMEOUT = 4000;

  typedef struct packed {
    sampler_mode_e     mode;
    logic [ADDR_W-1:0] base;
    int unsigned       gap_pct;
    int unsigned       word_limit;
  } job_t;

  logic              clk = 1'b0;
  logic              rst_b;
  logic              start_i;
  sampler_mode_e     mode_i;
  logic [ADDR_W-1:0] dest_base_addr_i;
  logic              word_valid_i;
  logic [WORD_W-1:0] word_i;
  logic              word_hold_o;
  logic              busy_o;
  logic              done_o;
  ntt_out_t          ntt_out_o;
  mem_wr_t           mem_wr_o;

  int                seed = 32'he35b_524f;
  job_t              job_tab [NUM_JOBS];
  sampler_mode_e     job_mode;
  logic [ADDR_W-1:0] job_base;
  int unsigned       gap_pct;
  int unsigned       word_limit;
  int unsigned       words_taken;
  int                beat_cnt;
  logic              consumed;
  logic              done_due;
  logic              done_seen;
  coeff_t            exp_q [$];

  always #5 clk = ~clk;

  sampler_top i_dut (
    .clk              (clk),
    .rst_b            (rst_b),
    .start_i          (start_i),
    .mode_i           (mode_i),
    .dest_base_addr_i (dest_base_addr_i),
    .word_valid_i     (word_valid_i),
    .word_i           (word_i),
    .word_hold_o      (word_hold_o),
    .busy_o           (busy_o),
    .done_o           (done_o),
    .ntt_out_o        (ntt_out_o),
    .mem_wr_o         (mem_wr_o)
  );

  task automatic report_fail();
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped at the first failing check");
  endtask

  // random word, about one chunk in eight forced into the reject band above q
  function automatic logic [WORD_W-1:0] gen_word();
    logic [WORD_W-1:0] w;
    int unsigned       r;
    w = {$random(seed), $random(seed), $random(seed)};
    for (int k = 0; k < 4; k++) begin
      r = $unsigned($random(seed));
      if (r[2:0] == 3'd0) begin
        w[24*k +: 23] = 23'h7FE001 + 23'(r[31:19] % 13'd8191);
      end
    end
    return w;
  endfunction

  // 24-bit chunks low to high, top bit dropped, keep below q
  function automatic void model_uniform(input logic [WORD_W-1:0] w);
    logic [22:0] m;
    for (int k = 0; k < WORD_W / 24; k++) begin
      m = w[24*k +: 23];
      if ({9'd0, m} < DILITHIUM_Q) begin
        exp_q.push_back(m);
      end
    end
  endfunction

  // nibbles low to high, keep below 15, value is 2 - (b mod 5) mod q
  function automatic void model_bounded(input logic [WORD_W-1:0] w);
    logic [3:0] b;
    int         v;
    for (int k = 0; k < WORD_W / 4; k++) begin
      b = w[4*k +: 4];
      if (int'(b) < REJB_LIMIT) begin
        v = ETA - (int'(b) % 5);
        if (v < 0) begin
          v = v + int'(DILITHIUM_Q);
        end
        exp_q.push_back(coeff_t'(v));
      end
    end
  endfunction

  task automatic check_beat(input coeff_t [COEFF_PER_CLK-1:0] data, input string port);
    coeff_t exp;
    for (int k = 0; k < COEFF_PER_CLK; k++) begin
      assert (exp_q.size() > 0) else begin
        $display("%s beat %0d arrived with no expected coefficient left", port, beat_cnt);
        report_fail();
      end
      exp = exp_q.pop_front();
      assert (data[k] == exp) else begin
        $display("Mismatch %s.data[%0d]: got %h expected %h", port, k, data[k], exp);
        report_fail();
      end
    end
  endtask

  task automatic expect_low(input logic value, input string name);
    assert (value === 1'b0) else begin
      $display("Mismatch %s after reset: got %h expected 0", name, value);
      report_fail();
    end
  endtask

  // word source, new word or gap once the current one is taken
  always @(posedge clk) begin : drive_words
    int unsigned r;
    if (rst_b && (!word_valid_i || consumed)) begin
      r = $unsigned($random(seed)) % 100;
      if (r < gap_pct) begin
        word_valid_i <= 1'b0;
      end else begin
        word_valid_i <= 1'b1;
        word_i       <= gen_word();
      end
    end
  end

  // outputs sampled mid-cycle, consumption decided for the next edge
  always @(negedge clk) begin : monitor
    logic [ADDR_W-1:0] exp_addr;
    consumed = 1'b0;
    if (rst_b) begin
      if (done_due) begin
        assert (done_o && !busy_o) else begin
          $display("done_o did not pulse with busy_o low one cycle after the last beat");
          report_fail();
        end
        done_seen = 1'b1;
      end else begin
        assert (!done_o) else begin
          $display("done_o high outside the cycle after the last beat");
          report_fail();
        end
      end
      done_due = 1'b0;
      assert (busy_o || !word_hold_o) else begin
        $display("word_hold_o high while no job is running");
        report_fail();
      end
      assert (!(ntt_out_o.dv && job_mode == MODE_REJ_BOUNDED)) else begin
        $display("ntt_out_o.dv high during a bounded job");
        report_fail();
      end
      assert (!(mem_wr_o.dv && job_mode == MODE_REJ_UNIFORM)) else begin
        $display("mem_wr_o.dv high during a uniform job");
        report_fail();
      end
      if (ntt_out_o.dv) begin
        check_beat(ntt_out_o.data, "ntt_out_o");
      end
      if (mem_wr_o.dv) begin
        exp_addr = job_base + ADDR_W'(beat_cnt);
        assert (mem_wr_o.addr == exp_addr) else begin
          $display("Mismatch mem_wr_o.addr: got %h expected %h", mem_wr_o.addr, exp_addr);
          report_fail();
        end
        check_beat(mem_wr_o.data, "mem_wr_o");
      end
      if (ntt_out_o.dv || mem_wr_o.dv) begin
        beat_cnt++;
        assert (beat_cnt <= BEATS_PER_POLY) else begin
          $display("more than %0d beats in one job", BEATS_PER_POLY);
          report_fail();
        end
        done_due = (beat_cnt == BEATS_PER_POLY);
      end
      if (word_valid_i && !word_hold_o && busy_o) begin
        consumed = 1'b1;
        words_taken++;
        assert (words_taken <= word_limit) else begin
          $display("job took more than %0d words without finishing", word_limit);
          report_fail();
        end
        if (job_mode == MODE_REJ_UNIFORM) begin
          model_uniform(word_i);
        end else begin
          model_bounded(word_i);
        end
      end
    end
  end

  function automatic void fill_job_table();
    job_tab[0] = '{MODE_REJ_UNIFORM, 14'h0000, 0, 100};
    job_tab[1] = '{MODE_REJ_BOUNDED, 14'h0100, 25, 24};
    job_tab[2] = '{MODE_REJ_UNIFORM, 14'h2000, 40, 100};
    job_tab[3] = '{MODE_REJ_BOUNDED, 14'h3FE0, 50, 24};
    job_tab[4] = '{MODE_REJ_UNIFORM, 14'h0040, 0, 100};
    job_tab[5] = '{MODE_REJ_BOUNDED, 14'h1234, 10, 24};
  endfunction

  // entered and left on a rising edge
  task automatic run_job(input job_t job);
    int cyc;
    job_mode    = job.mode;
    job_base    = job.base;
    word_limit  = job.word_limit;
    words_taken = 0;
    beat_cnt    = 0;
    done_seen   = 1'b0;
    exp_q.delete();
    @(negedge clk);
    gap_pct = job.gap_pct;
    @(posedge clk);
    start_i          <= 1'b1;
    mode_i           <= job.mode;
    dest_base_addr_i <= job.base;
    @(posedge clk);
    start_i <= 1'b0;
    @(negedge clk);
    assert (busy_o) else begin
      $display("busy_o did not rise in the cycle after start_i");
      report_fail();
    end
    cyc = 0;
    while (!done_seen) begin
      @(posedge clk);
      cyc++;
      assert (cyc < JOB_TIMEOUT) else begin
        $display("timeout waiting for done_o after %0d cycles", cyc);
        report_fail();
      end
    end
  endtask

  initial begin
    rst_b            = 1'b0;
    start_i          = 1'b0;
    mode_i           = MODE_REJ_UNIFORM;
    dest_base_addr_i = '0;
    word_valid_i     = 1'b0;
    word_i           = '0;
    job_mode         = MODE_REJ_UNIFORM;
    job_base         = '0;
    gap_pct          = 0;
    word_limit       = 0;
    words_taken      = 0;
    beat_cnt         = 0;
    consumed         = 1'b0;
    done_due         = 1'b0;
    done_seen        = 1'b0;
    fill_job_table();
    repeat (10) @(posedge clk);
    rst_b <= 1'b1;
    @(negedge clk);
    expect_low(busy_o, "busy_o");
    expect_low(done_o, "done_o");
    expect_low(ntt_out_o.dv, "ntt_out_o.dv");
    expect_low(mem_wr_o.dv, "mem_wr_o.dv");
    expect_low(word_hold_o, "word_hold_o");
    @(posedge clk);
    for (int j = 0; j < NUM_JOBS; j++) begin
      run_job(job_tab[j]);
    end
    // idle tail, stray beats or done pulses still get caught
    repeat (8) @(posedge clk);
    $display("NO ERRORS");
    $finish;
  end

endmodule
